/* rd_stream_source.f */
src/rd_stream_pkg.sv
src/rd_beat_if.sv
src/rd_stream_fsm.sv
src/rd_addr_gen.sv
src/rd_offset_fifo.sv
src/rd_realign.sv
src/rd_stream_source.sv
tb/tb_mem_model.sv
tb/tb_rd_stream_source.sv

/* src/rd_addr_gen.sv */
// one-dimensional pattern only; address wraps silently past the top of the space
`timescale 1ns/100ps
`default_nettype none

module rd_addr_gen (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 clear_i,
  input  wire logic                 load_i,      // latch a new job
  input  wire logic                 en_i,        // allowed to offer addresses
  input  wire rd_stream_pkg::addr_t base_addr_i,
  input  wire rd_stream_pkg::addr_t stride_i,
  input  wire rd_stream_pkg::cnt_t  len_i,
  output logic                      addr_valid_o,
  input  wire logic                 addr_ready_i,
  output rd_stream_pkg::addr_t      addr_o,
  output logic                      done_o       // level, count reached length
);

  rd_stream_pkg::addr_t addr_q;
  rd_stream_pkg::addr_t stride_q;
  rd_stream_pkg::cnt_t  len_q;
  rd_stream_pkg::cnt_t  trans_cnt_q; // issued transactions
  logic                 addr_fire;

  assign done_o       = (trans_cnt_q == len_q);
  assign addr_valid_o = en_i & ~done_o;
  assign addr_o       = addr_q;
  assign addr_fire    = addr_valid_o & addr_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q      <= '0;
      stride_q    <= '0;
      len_q       <= '0;
      trans_cnt_q <= '0;
    end else if (clear_i) begin
      addr_q      <= '0;
      stride_q    <= '0;
      len_q       <= '0;
      trans_cnt_q <= '0;
    end else if (load_i) begin
      addr_q      <= base_addr_i;
      stride_q    <= stride_i;
      len_q       <= len_i;
      trans_cnt_q <= '0;
    end else if (addr_fire) begin
      addr_q      <= addr_q + stride_q; // next byte address
      trans_cnt_q <= trans_cnt_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* src/rd_beat_if.sv */
// carries one memory response already paired with its byte offset, valid/ready handshake
`timescale 1ns/100ps
`default_nettype none

interface rd_beat_if;

  logic                   valid;  // response word present
  logic                   ready;  // realigner slot can take it
  rd_stream_pkg::mem_data_t data;   // raw 64-bit word
  rd_stream_pkg::offset_t   offset; // byte offset from the FIFO head

  // response side
  modport source (output valid, output data, output offset, input ready);
  // realigner side
  modport sink (input valid, input data, input offset, output ready);

endinterface

`default_nettype wire

/* src/rd_offset_fifo.sv */
// registered head only, no fall-through; depth must be a power of two
`timescale 1ns/100ps
`default_nettype none

module rd_offset_fifo (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   clear_i,
  input  wire logic                   push_i,   // read issued
  input  wire rd_stream_pkg::offset_t offset_i,
  input  wire logic                   pop_i,    // response accepted
  output rd_stream_pkg::offset_t      offset_o, // offset of oldest outstanding read
  output logic                        full_o,
  output logic                        empty_o
);

  localparam int unsigned PTR_W = rd_stream_pkg::OFFSET_PTR_W;

  // extra msb tells full from empty
  logic [PTR_W:0] wr_ptr_q;
  logic [PTR_W:0] rd_ptr_q;

  rd_stream_pkg::offset_t mem_q [rd_stream_pkg::OFFSET_DEPTH];

  assign empty_o  = (wr_ptr_q == rd_ptr_q);
  assign full_o   = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) &&
                    (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);
  assign offset_o = mem_q[rd_ptr_q[PTR_W-1:0]];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_i)  rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  // storage, no reset
  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q[PTR_W-1:0]] <= offset_i;
  end

  // request gating upstream should keep this from ever firing
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o)
    else $error("offset FIFO push while full");

  // memory answered a read that was never issued
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty_o)
    else $error("offset FIFO pop while empty");

endmodule

`default_nettype wire

/* src/rd_realign.sv */
// offsets 0 to 3 only; holds one beat so memory sees back-pressure straight away
`timescale 1ns/100ps
`default_nettype none

module rd_realign (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               clear_i,
  rd_beat_if.sink                 beat,
  output logic                    stream_valid_o,
  input  wire logic               stream_ready_i,
  output rd_stream_pkg::stream_data_t stream_data_o
);

  logic                        slot_valid_q;
  rd_stream_pkg::stream_data_t slot_data_q; // payload, no reset
  rd_stream_pkg::mem_data_t    shifted;
  logic                        beat_fire;

  // empty slot, or slot leaving this cycle
  assign beat.ready = ~slot_valid_q | stream_ready_i;
  assign beat_fire  = beat.valid & beat.ready;

  // drop the leading bytes, low STREAM_DW bits are the beat
  assign shifted = beat.data >> {beat.offset, 3'b000};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_valid_q <= 1'b0;
    end else if (clear_i) begin
      slot_valid_q <= 1'b0;
    end else if (beat_fire) begin
      slot_valid_q <= 1'b1;
    end else if (stream_ready_i) begin
      slot_valid_q <= 1'b0; // beat taken, nothing new
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_fire) slot_data_q <= shifted[rd_stream_pkg::STREAM_DW-1:0];
  end

  assign stream_valid_o = slot_valid_q;
  assign stream_data_o  = slot_data_q;

  // stream protocol, a stalled beat keeps its data
  a_hold_data: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    stream_valid_o && !stream_ready_i |=> $stable(stream_data_o))
    else $error("stream data changed while stalled");

endmodule

`default_nettype wire

/* src/rd_stream_fsm.sv */
// one job at a time; start with zero length is illegal and start during a job is ignored
`timescale 1ns/100ps
`default_nettype none

module rd_stream_fsm (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                clear_i,
  input  wire logic                start_i,
  input  wire rd_stream_pkg::cnt_t len_i,
  input  wire logic                gen_done_i,  // all addresses issued
  input  wire logic                beat_fire_i, // stream beat accepted
  output logic                     gen_load_o,
  output logic                     gen_en_o,
  output logic                     ready_start_o,
  output logic                     done_o
);

  rd_stream_pkg::stream_state_e state_q, state_d;
  rd_stream_pkg::cnt_t          len_q;      // job length, latched on start
  rd_stream_pkg::cnt_t          beat_cnt_q; // accepted beats so far

  assign ready_start_o = (state_q == rd_stream_pkg::ST_IDLE);
  assign gen_en_o      = (state_q == rd_stream_pkg::ST_WORKING);
  assign gen_load_o    = ready_start_o & start_i; // start accepted

  always_comb begin
    state_d = state_q;
    done_o  = 1'b0;
    case (state_q)
      rd_stream_pkg::ST_IDLE: begin
        if (start_i) state_d = rd_stream_pkg::ST_WORKING;
      end
      rd_stream_pkg::ST_WORKING: begin
        if (gen_done_i) state_d = rd_stream_pkg::ST_DRAIN; // last read issued
      end
      rd_stream_pkg::ST_DRAIN: begin
        if (beat_cnt_q == len_q) begin // every beat out
          done_o  = 1'b1;
          state_d = rd_stream_pkg::ST_IDLE;
        end
      end
      default: state_d = rd_stream_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= rd_stream_pkg::ST_IDLE;
      len_q      <= '0;
      beat_cnt_q <= '0;
    end else if (clear_i) begin
      state_q    <= rd_stream_pkg::ST_IDLE;
      len_q      <= '0;
      beat_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (gen_load_o) begin
        len_q      <= len_i;
        beat_cnt_q <= '0; // fresh count per job
      end else if (beat_fire_i) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
    end
  end

  // a zero-length job would never reach done
  a_start_len: assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_i && ready_start_o |-> len_i != '0)
    else $error("start accepted with zero length");

endmodule

`default_nettype wire

/* src/rd_stream_pkg.sv */
// assumes a 64-bit memory word twice the stream width so any byte offset fits in one read
`default_nettype none

package rd_stream_pkg;

  // bus widths
  localparam int unsigned ADDR_W    = 32; // byte address
  localparam int unsigned MEM_DW    = 64; // memory read word
  localparam int unsigned STREAM_DW = 32; // output beat
  localparam int unsigned CNT_W     = 16; // transfer count, max 65535 beats

  // byte offset of a beat inside a memory word
  localparam int unsigned OFFSET_W = $clog2(STREAM_DW / 8);

  // outstanding read limit
  localparam int unsigned OFFSET_DEPTH = 8;
  localparam int unsigned OFFSET_PTR_W = $clog2(OFFSET_DEPTH); // must be a power of two

  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [MEM_DW-1:0]    mem_data_t;
  typedef logic [STREAM_DW-1:0] stream_data_t;
  typedef logic [CNT_W-1:0]     cnt_t;
  typedef logic [OFFSET_W-1:0]  offset_t;

  // job states
  typedef enum logic [1:0] {
    ST_IDLE,    // waiting for start, ready_start high
    ST_WORKING, // generator still issuing reads
    ST_DRAIN    // all reads issued, waiting for the last beats
  } stream_state_e;

endpackage

`default_nettype wire

/* src/rd_stream_source.sv */
// memory must answer in request order; responses are only taken while a job runs
`timescale 1ns/100ps
`default_nettype none

module rd_stream_source (
  input  wire logic                        clk_i,
  input  wire logic                        rst_ni,
  // control
  input  wire logic                        start_i,
  input  wire logic                        clear_i,
  input  wire rd_stream_pkg::addr_t        base_addr_i,
  input  wire rd_stream_pkg::addr_t        stride_i,
  input  wire rd_stream_pkg::cnt_t         len_i,
  output logic                             ready_start_o,
  output logic                             done_o,
  // memory request
  output logic                             mem_req_valid_o,
  input  wire logic                        mem_req_ready_i,
  output rd_stream_pkg::addr_t             mem_req_addr_o,
  // memory response
  input  wire logic                        mem_resp_valid_i,
  output logic                             mem_resp_ready_o,
  input  wire rd_stream_pkg::mem_data_t    mem_resp_data_i,
  // stream out
  output logic                             stream_valid_o,
  input  wire logic                        stream_ready_i,
  output rd_stream_pkg::stream_data_t      stream_data_o
);

  localparam int unsigned OW = rd_stream_pkg::OFFSET_W;

  logic                   gen_load, gen_en, gen_done;
  logic                   addr_valid, addr_ready;
  rd_stream_pkg::addr_t   addr;
  logic                   fifo_full, fifo_empty;
  logic                   req_fire, resp_fire, busy;
  rd_stream_pkg::offset_t head_offset;

  rd_beat_if beat_if ();

  rd_stream_fsm i_fsm (
    .clk_i, .rst_ni, .clear_i, .start_i, .len_i,
    .gen_done_i    ( gen_done                        ),
    .beat_fire_i   ( stream_valid_o & stream_ready_i ),
    .gen_load_o    ( gen_load                        ),
    .gen_en_o      ( gen_en                          ),
    .ready_start_o ( ready_start_o                   ),
    .done_o        ( done_o                          )
  );

  rd_addr_gen i_addr_gen (
    .clk_i, .rst_ni, .clear_i, .base_addr_i, .stride_i, .len_i,
    .load_i ( gen_load ), .en_i ( gen_en ),
    .addr_valid_o ( addr_valid ), .addr_ready_i ( addr_ready ),
    .addr_o ( addr ), .done_o ( gen_done )
  );

  // request side, blocked while every FIFO slot holds an outstanding read
  assign mem_req_valid_o = addr_valid & ~fifo_full;
  assign addr_ready      = mem_req_ready_i & ~fifo_full;
  assign mem_req_addr_o  = {addr[rd_stream_pkg::ADDR_W-1:OW], {OW{1'b0}}}; // word aligned
  assign req_fire        = mem_req_valid_o & mem_req_ready_i;

  rd_offset_fifo i_offset_fifo (
    .clk_i, .rst_ni, .clear_i,
    .push_i ( req_fire ), .offset_i ( addr[OW-1:0] ),
    .pop_i ( resp_fire ), .offset_o ( head_offset ),
    .full_o ( fifo_full ), .empty_o ( fifo_empty )
  );

  // response side
  assign busy             = ~ready_start_o;
  assign beat_if.valid    = mem_resp_valid_i & busy;
  assign beat_if.data     = mem_resp_data_i;
  assign beat_if.offset   = head_offset;
  assign mem_resp_ready_o = beat_if.ready & busy;
  assign resp_fire        = mem_resp_valid_i & mem_resp_ready_o;

  rd_realign i_realign (
    .clk_i, .rst_ni, .clear_i,
    .beat ( beat_if.sink ),
    .stream_valid_o, .stream_ready_i, .stream_data_o
  );

  // done only once every issued read has come back
  a_done_drained: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |-> fifo_empty)
    else $error("done with reads still outstanding");

endmodule

`default_nettype wire

/* tb/tb_mem_model.sv */
// in-order read memory for simulation only; byte at address a reads as a[7:0] ^ 8'h5a
`timescale 1ns/100ps
`default_nettype none

module tb_mem_model (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      flush_i,   // drop every pending read
  input  wire logic [7:0]                lat_max_i, // longest response delay in cycles
  input  wire logic                      req_valid_i,
  output logic                           req_ready_o,
  input  wire rd_stream_pkg::addr_t      req_addr_i,
  output logic                           resp_valid_o,
  input  wire logic                      resp_ready_i,
  output rd_stream_pkg::mem_data_t       resp_data_o
);

  rd_stream_pkg::mem_data_t data_q [$]; // words of accepted reads, oldest first
  longint unsigned          due_q [$];  // cycle each read may answer
  longint unsigned          cycle;

  // eight little-endian bytes from address a
  function automatic rd_stream_pkg::mem_data_t word_at(input rd_stream_pkg::addr_t a);
    rd_stream_pkg::mem_data_t w;
    rd_stream_pkg::addr_t     ba;
    for (int i = 0; i < 8; i++) begin
      ba = a + i;
      w[8*i +: 8] = ba[7:0] ^ 8'h5A;
    end
    return w;
  endfunction

  initial begin
    req_ready_o  = 1'b0;
    resp_valid_o = 1'b0;
    resp_data_o  = '0;
    cycle        = 0;
  end

  always @(posedge clk_i or negedge rst_ni) begin : model_proc
    logic showing; // head word still offered after this edge
    if (!rst_ni) begin
      cycle = 0;
      data_q.delete();
      due_q.delete();
      req_ready_o  <= 1'b0;
      resp_valid_o <= 1'b0;
      resp_data_o  <= '0;
    end else begin
      cycle   = cycle + 1;
      showing = resp_valid_o;
      if (req_valid_i && req_ready_o) begin
        data_q.push_back(word_at(req_addr_i));
        due_q.push_back(cycle + $urandom_range(lat_max_i, 1)); // 1..lat_max later
      end
      if (resp_valid_o && resp_ready_i) begin // head taken
        void'(data_q.pop_front());
        void'(due_q.pop_front());
        showing = 1'b0;
      end
      if (flush_i) begin
        data_q.delete();
        due_q.delete();
        resp_valid_o <= 1'b0;
      end else if (!showing) begin
        if (due_q.size() > 0 && due_q[0] <= cycle) begin
          resp_valid_o <= 1'b1; // oldest read only, keeps order
          resp_data_o  <= data_q[0];
        end else begin
          resp_valid_o <= 1'b0;
        end
      end
      req_ready_o <= ($urandom_range(3) != 0); // grant about 3 of 4 cycles
    end
  end

endmodule

`default_nettype wire

/* tb/tb_rd_stream_source.sv */
// runs the six job scenarios against a random-latency memory; the watchdog bounds the run
`timescale 1ns/100ps
`default_nettype none

module tb_rd_stream_source;

  // 16 + 3*12 + 48 + 32 + 20 + 40 + 16 beats over all jobs
  localparam int SUM_LEN     = 208;
  localparam int WD_CYCLES   = SUM_LEN * 40 + 2000; // margin covers reset and gaps

  logic                         clk_i, rst_ni;
  logic                         start_i, clear_i;
  rd_stream_pkg::addr_t         base_addr_i, stride_i;
  rd_stream_pkg::cnt_t          len_i;
  logic                         ready_start_o, done_o;
  logic                         mem_req_valid_o, mem_req_ready_i;
  rd_stream_pkg::addr_t         mem_req_addr_o;
  logic                         mem_resp_valid_i, mem_resp_ready_o;
  rd_stream_pkg::mem_data_t     mem_resp_data_i;
  logic                         stream_valid_o, stream_ready_i;
  rd_stream_pkg::stream_data_t  stream_data_o;

  logic                 bp_en;      // random stream back-pressure
  logic [7:0]           lat_max;    // memory delay limit
  rd_stream_pkg::addr_t job_base, job_stride;
  rd_stream_pkg::cnt_t  job_len;    // beats expected in the running job
  int                   beat_idx, req_idx, done_cnt, outstanding;
  int                   errors, test_err_base, n_tests, n_failed;
  string                cur_test;

  rd_stream_source UUT (.*);

  tb_mem_model i_mem (
    .clk_i, .rst_ni, .flush_i ( clear_i ), .lat_max_i ( lat_max ),
    .req_valid_i ( mem_req_valid_o ), .req_ready_o ( mem_req_ready_i ),
    .req_addr_i ( mem_req_addr_o ),
    .resp_valid_o ( mem_resp_valid_i ), .resp_ready_i ( mem_resp_ready_o ),
    .resp_data_o ( mem_resp_data_i )
  );

  always #4 clk_i = ~clk_i; // 8 ns period

  // beat k is the four bytes from base + k*stride, little-endian
  function automatic rd_stream_pkg::stream_data_t ref_beat(input rd_stream_pkg::addr_t base,
      input rd_stream_pkg::addr_t stride, input int k);
    rd_stream_pkg::stream_data_t b;
    rd_stream_pkg::addr_t        a;
    rd_stream_pkg::addr_t        ba;
    a = base + stride * k;
    for (int i = 0; i < 4; i++) begin
      ba = a + i;
      b[8*i +: 8] = ba[7:0] ^ 8'h5A;
    end
    return b;
  endfunction

  // read k asks for the word holding base + k*stride, low two bits cleared
  function automatic rd_stream_pkg::addr_t ref_req_addr(input rd_stream_pkg::addr_t base,
      input rd_stream_pkg::addr_t stride, input int k);
    rd_stream_pkg::addr_t a;
    a      = base + stride * k;
    a[1:0] = 2'b00;
    return a;
  endfunction

  task automatic check_value(input string what, input logic [63:0] expected,
      input logic [63:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("MISMATCH %s %s expected 0x%0h actual 0x%0h", cur_test, what, expected, actual);
    end
  endtask

  task automatic open_test(input string name);
    cur_test      = name;
    test_err_base = errors;
  endtask

  task automatic close_test();
    n_tests++;
    if (errors == test_err_base) begin
      $display("test %s ok", cur_test);
    end else begin
      n_failed++;
      $display("test %s failed with %0d errors", cur_test, errors - test_err_base);
    end
  endtask

  // start a job and return once it is running
  task automatic launch_job(input rd_stream_pkg::addr_t base, input rd_stream_pkg::addr_t stride,
      input rd_stream_pkg::cnt_t len);
    check_value("idle_before_start", 1, ready_start_o);
    job_base   = base;
    job_stride = stride;
    job_len    = len;
    beat_idx   = 0;
    req_idx    = 0;
    done_cnt   = 0;
    @(posedge clk_i);
    start_i     <= 1'b1;
    base_addr_i <= base;
    stride_i    <= stride;
    len_i       <= len;
    @(posedge clk_i);
    start_i <= 1'b0;
    @(posedge clk_i);
    check_value("busy_flag", 0, ready_start_o);
  endtask

  task automatic run_job(input rd_stream_pkg::addr_t base, input rd_stream_pkg::addr_t stride,
      input rd_stream_pkg::cnt_t len, input bit poke_start);
    launch_job(base, stride, len);
    if (poke_start) begin
      start_i <= 1'b1; // must be ignored while busy
      len_i   <= 16'd3;
      @(posedge clk_i);
      start_i <= 1'b0;
    end
    while (!done_o) @(posedge clk_i);
    @(posedge clk_i);
    check_value("idle_after_done", 1, ready_start_o);
    @(posedge clk_i); // checker has seen every done cycle by now
    check_value("beat_count", len, beat_idx);
    check_value("req_count", len, req_idx);
    check_value("done_pulses", 1, done_cnt);
  endtask

  // clear a running job once some beats are out
  task automatic abort_job(input rd_stream_pkg::addr_t base, input rd_stream_pkg::addr_t stride,
      input rd_stream_pkg::cnt_t len, input int after_beats);
    launch_job(base, stride, len);
    while (beat_idx < after_beats) @(posedge clk_i);
    clear_i <= 1'b1;
    @(posedge clk_i);
    clear_i <= 1'b0;
    @(posedge clk_i);
    check_value("idle_after_clear", 1, ready_start_o);
    check_value("stream_empty", 0, stream_valid_o);
    check_value("no_done_on_clear", 0, done_cnt);
  endtask

  // compare every accepted beat and read, count done pulses and reads in flight
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (done_o) begin
        check_value("beats_at_done", job_len, beat_idx); // last beat one cycle before
        done_cnt = done_cnt + 1;
      end
      if (stream_valid_o && stream_ready_i) begin
        check_value($sformatf("beat %0d", beat_idx),
                    ref_beat(job_base, job_stride, beat_idx), stream_data_o);
        check_value("busy_during_beat", 0, ready_start_o);
        beat_idx = beat_idx + 1;
      end
      if (mem_req_valid_o && mem_req_ready_i) begin
        check_value($sformatf("req_addr %0d", req_idx),
                    ref_req_addr(job_base, job_stride, req_idx), mem_req_addr_o);
        req_idx     = req_idx + 1;
        outstanding = outstanding + 1;
      end
      if (mem_resp_valid_i && mem_resp_ready_o) outstanding = outstanding - 1;
      if (clear_i) outstanding = 0;
      if (outstanding > rd_stream_pkg::OFFSET_DEPTH)
        check_value("outstanding_limit", rd_stream_pkg::OFFSET_DEPTH, outstanding);
    end
  end

  always @(posedge clk_i) begin
    stream_ready_i <= bp_en ? ($urandom_range(3) != 0) : 1'b1;
  end

  initial begin
    repeat (WD_CYCLES) @(posedge clk_i);
    $display("timeout, jobs did not finish within %0d cycles", WD_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    void'($urandom(35316));
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    start_i        = 1'b0;
    clear_i        = 1'b0;
    base_addr_i    = '0;
    stride_i       = '0;
    len_i          = '0;
    stream_ready_i = 1'b0;
    bp_en          = 1'b0;
    lat_max        = 8'd6;
    job_base       = '0;
    job_stride     = '0;
    job_len        = '0;
    beat_idx       = 0;
    req_idx        = 0;
    done_cnt       = 0;
    outstanding    = 0;
    errors         = 0;
    test_err_base  = 0;
    n_tests        = 0;
    n_failed       = 0;
    cur_test       = "reset";
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    open_test("aligned_contiguous");
    check_value("idle_after_reset", 1, ready_start_o);
    run_job(32'h0000_1000, 32'd4, 16'd16, 1'b0);
    close_test();

    open_test("misaligned");
    run_job(32'h0000_0101, 32'd5, 16'd12, 1'b0); // offset 1
    run_job(32'h0000_2002, 32'd7, 16'd12, 1'b0); // offset 2
    run_job(32'h0000_3ff3, 32'd3, 16'd12, 1'b0); // offset 3
    close_test();

    open_test("backpressure");
    bp_en <= 1'b1;
    run_job(32'h4000_0010, 32'd6, 16'd48, 1'b0);
    bp_en <= 1'b0;
    close_test();

    open_test("long_latency");
    lat_max <= 8'd24; // deep enough to fill the offset FIFO
    run_job(32'h0000_0800, 32'd9, 16'd32, 1'b0);
    lat_max <= 8'd6;
    close_test();

    open_test("idle_flags");
    run_job(32'h0000_5000, 32'd4, 16'd20, 1'b1);
    close_test();

    open_test("clear_mid_job");
    abort_job(32'h0000_6000, 32'd4, 16'd40, 5);
    run_job(32'h0000_7001, 32'd3, 16'd16, 1'b0);
    close_test();

    $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
